//--- build.f
design/fifo_pkg.sv
design/skid_buffer.sv
design/sync_simple_dual_ram.sv
design/axis_fifo_sync.sv
design/stream_fifo_top.sv
tests/stream_fifo_chk.sv
tests/tb_stream_fifo.sv

//--- design/axis_fifo_sync.sv
`timescale 1ns/1ps
`default_nettype none

module axis_fifo_sync (
    input  logic                            clk,
    input  logic                            rst,
    // write stream
    input  logic [fifo_pkg::DATA_WIDTH-1:0] write_tdata,
    input  logic                            write_tvalid,
    output logic                            write_tready,
    // read stream
    output logic [fifo_pkg::DATA_WIDTH-1:0] read_tdata,
    output logic                            read_tvalid,
    input  logic                            read_tready
);

    // write side
    logic [fifo_pkg::DATA_WIDTH-1:0] write_data;
    logic                            write_valid;
    logic                            write_ready;
    logic                            ram_we;

    // pointers and flags
    logic [fifo_pkg::PTR_WIDTH-1:0]  wr_ptr;
    logic [fifo_pkg::PTR_WIDTH-1:0]  rd_ptr;
    logic                            fifo_full;
    logic                            fifo_empty;

    // read side
    logic [fifo_pkg::DATA_WIDTH-1:0] ram_data;
    logic                            rd_issue;
    logic [fifo_pkg::RAM_LATENCY-1:0] rd_pipe;
    logic                            ram_valid;
    logic                            stall_flag;
    logic [fifo_pkg::DATA_WIDTH-1:0] stall_data;
    logic                            stall_capture;
    logic [fifo_pkg::DATA_WIDTH-1:0] out_data;
    logic                            out_valid;
    logic                            read_ready;
    logic                            rd_done;
    logic [1:0]                      in_flight;

    skid_buffer skid_buffer_write (
        .clk        (clk),
        .rst        (rst),
        .din        (write_tdata),
        .din_valid  (write_tvalid),
        .din_ready  (write_tready),
        .dout       (write_data),
        .dout_valid (write_valid),
        .dout_ready (write_ready)
    );

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[fifo_pkg::PTR_WIDTH-1] != rd_ptr[fifo_pkg::PTR_WIDTH-1]) &&
                        (wr_ptr[fifo_pkg::ADDR_WIDTH-1:0] == rd_ptr[fifo_pkg::ADDR_WIDTH-1:0]);

    assign write_ready = ~fifo_full;
    assign ram_we      = write_valid & write_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (ram_we) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    sync_simple_dual_ram ram_inst (
        .clk   (clk),
        .wea   (ram_we),
        .addra (wr_ptr[fifo_pkg::ADDR_WIDTH-1:0]),
        .dina  (write_data),
        .addrb (rd_ptr[fifo_pkg::ADDR_WIDTH-1:0]),
        .doutb (ram_data)
    );

    // Words past the RAM read port have three places to sit: the two
    // registers of the output skid and the stall register. in_flight counts
    // words from read issue until they leave on the read stream, so a read is
    // only started when a landing place is guaranteed for its data.
    assign rd_done  = read_tvalid & read_tready;
    assign rd_issue = ~fifo_empty & read_ready & (in_flight != 2'd3);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr    <= '0;
            rd_pipe   <= '0;
            in_flight <= 2'd0;
        end else begin
            if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            rd_pipe   <= {rd_pipe[fifo_pkg::RAM_LATENCY-2:0], rd_issue};
            in_flight <= in_flight + {1'b0, rd_issue} - {1'b0, rd_done};
        end
    end

    assign ram_valid = rd_pipe[fifo_pkg::RAM_LATENCY-1]; // doutb holds a word

    // stall word always goes out ahead of the live ram word
    assign out_valid = stall_flag | ram_valid;
    assign out_data  = stall_flag ? stall_data : ram_data;

    // ram word cannot go straight into the output skid
    assign stall_capture = ram_valid & (stall_flag | ~read_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_flag <= 1'b0;
        end else begin
            stall_flag <= stall_capture | (stall_flag & ~read_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (stall_capture) begin
            stall_data <= ram_data;
        end
    end

    skid_buffer skid_buffer_read (
        .clk        (clk),
        .rst        (rst),
        .din        (out_data),
        .din_valid  (out_valid),
        .din_ready  (read_ready),
        .dout       (read_tdata),
        .dout_valid (read_tvalid),
        .dout_ready (read_tready)
    );

endmodule

`default_nettype wire

//--- design/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

    // stream word and ram word width
    localparam int DATA_WIDTH = 32;

    // ram addressing
    localparam int ADDR_WIDTH = 4;
    localparam int DEPTH = 2 ** ADDR_WIDTH; // 16 entries

    // extra top bit tells full from empty
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    // read register plus output register
    localparam int RAM_LATENCY = 2;

endpackage

`default_nettype wire

//--- design/skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [fifo_pkg::DATA_WIDTH-1:0] din,
    input  logic                           din_valid,
    output logic                           din_ready,
    output logic [fifo_pkg::DATA_WIDTH-1:0] dout,
    output logic                           dout_valid,
    input  logic                           dout_ready
);

    logic [fifo_pkg::DATA_WIDTH-1:0] skid_data;
    logic                            skid_valid;
    logic                            in_xfer;
    logic                            main_free;

    assign in_xfer   = din_valid & din_ready;
    // main register is empty or is handing its word over this cycle
    assign main_free = ~dout_valid | dout_ready;

    // control state
    // din_ready is the inverse of skid_valid once out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
            skid_valid <= 1'b0;
            din_ready  <= 1'b0; // rises on the first edge after reset
        end else begin
            if (main_free) begin
                dout_valid <= skid_valid | in_xfer; // skid word first
                skid_valid <= 1'b0;
                din_ready  <= 1'b1;
            end else if (in_xfer) begin
                // park the word while the sink stalls
                skid_valid <= 1'b1;
                din_ready  <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                dout <= skid_data;
            end else begin
                dout <= din;
            end
        end
        if (!main_free && in_xfer) begin
            skid_data <= din; // extra word after ready drop
        end
    end

endmodule

`default_nettype wire

//--- design/stream_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo_top (
    input  logic                            clk,
    input  logic                            rst,
    // write stream from the source
    input  logic [fifo_pkg::DATA_WIDTH-1:0] write_tdata,
    input  logic                            write_tvalid,
    output logic                            write_tready,
    // read stream to the sink
    output logic [fifo_pkg::DATA_WIDTH-1:0] read_tdata,
    output logic                            read_tvalid,
    input  logic                            read_tready
);

    // single clock domain with sync reset
    axis_fifo_sync u_fifo (
        .clk          (clk),
        .rst          (rst),
        .write_tdata  (write_tdata),
        .write_tvalid (write_tvalid),
        .write_tready (write_tready),
        .read_tdata   (read_tdata),
        .read_tvalid  (read_tvalid),
        .read_tready  (read_tready)
    );

endmodule

`default_nettype wire

//--- design/sync_simple_dual_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_simple_dual_ram (
    input  logic                            clk,
    input  logic                            wea,
    input  logic [fifo_pkg::ADDR_WIDTH-1:0] addra,
    input  logic [fifo_pkg::DATA_WIDTH-1:0] dina,
    input  logic [fifo_pkg::ADDR_WIDTH-1:0] addrb,
    output logic [fifo_pkg::DATA_WIDTH-1:0] doutb
);

    logic [fifo_pkg::DATA_WIDTH-1:0] mem [0:fifo_pkg::DEPTH-1];
    logic [fifo_pkg::DATA_WIDTH-1:0] rd_reg;

    // write only port a
    always_ff @(posedge clk) begin
        if (wea) begin
            mem[addra] <= dina;
        end
    end

    // read port b through the array read register and the output register
    // two cycles from addrb to doutb as in block ram with its
    // output pipeline stage enabled
    always_ff @(posedge clk) begin
        rd_reg <= mem[addrb];
        doutb  <= rd_reg;
    end

endmodule

`default_nettype wire

//--- tests/stream_fifo_chk.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo_chk (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [fifo_pkg::DATA_WIDTH-1:0] write_tdata,
    input  logic                            write_tvalid,
    input  logic                            write_tready,
    input  logic [fifo_pkg::DATA_WIDTH-1:0] read_tdata,
    input  logic                            read_tvalid,
    input  logic                            read_tready
);

    localparam int DRAIN_LIMIT = 12; // idle cycles allowed with words waiting

    logic [fifo_pkg::DATA_WIDTH-1:0] ref_q [$]; // words accepted but not yet read
    logic [fifo_pkg::DATA_WIDTH-1:0] exp_word = '0;
    logic [fifo_pkg::DATA_WIDTH-1:0] held_word = '0;
    logic                            seen_edge = 1'b0;
    logic                            wr_xfer;
    logic                            rd_xfer;
    int                              q_count = 0;
    int                              blocked_writes = 0; // writes since the last read
    int                              starve = 0;
    int                              fail_count = 0;

    assign wr_xfer = write_tvalid & write_tready;
    assign rd_xfer = read_tvalid & read_tready;

    // reference model of the stored words
    always @(posedge clk) begin
        if (rst) begin
            ref_q.delete();
            blocked_writes <= 0;
            starve         <= 0;
        end else begin
            if (rd_xfer && ref_q.size() != 0) begin
                void'(ref_q.pop_front());
            end
            if (wr_xfer) begin
                ref_q.push_back(write_tdata);
            end
            if (rd_xfer) begin
                blocked_writes <= 0;
            end else if (wr_xfer) begin
                blocked_writes <= blocked_writes + 1;
            end
            if (q_count != 0 && read_tready && !rd_xfer) begin
                starve <= starve + 1; // sink waiting with nothing offered
            end else begin
                starve <= 0;
            end
        end
        q_count   <= ref_q.size();
        exp_word  <= (ref_q.size() != 0) ? ref_q[0] : '0;
        held_word <= read_tdata;
        seen_edge <= 1'b1;
    end

    a_order: assert property (@(posedge clk) disable iff (rst)
        rd_xfer && q_count != 0 |-> read_tdata == exp_word)
    else begin
        fail_count++;
        $error("Mismatch order: expected %h actual %h",
               $sampled(exp_word), $sampled(read_tdata));
    end

    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        rd_xfer |-> q_count != 0)
    else begin
        fail_count++;
        $error("Mismatch read count: expected no read with nothing stored, actual word %h",
               $sampled(read_tdata));
    end

    // output idle in reset and with nothing stored
    a_idle: assert property (@(posedge clk)
        seen_edge && (rst || q_count == 0) |-> !read_tvalid)
    else begin
        fail_count++;
        $error("Mismatch read_tvalid: expected 0 actual %b", $sampled(read_tvalid));
    end

    a_ready_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> ##[0:2] write_tready)
    else begin
        fail_count++;
        $error("Mismatch write_tready: expected 1 within two cycles of reset release, actual 0");
    end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        read_tvalid && !read_tready |=> read_tvalid && read_tdata == held_word)
    else begin
        fail_count++;
        $error("Mismatch held output: expected valid 1 data %h, actual valid %b data %h",
               $sampled(held_word), $sampled(read_tvalid), $sampled(read_tdata));
    end

    a_bound: assert property (@(posedge clk) disable iff (rst)
        q_count <= fifo_pkg::DEPTH + 6)
    else begin
        fail_count++;
        $error("Mismatch stored words: expected at most %0d actual %0d",
               fifo_pkg::DEPTH + 6, $sampled(q_count));
    end

    // write_tready must drop before this many unread accepts
    a_full: assert property (@(posedge clk) disable iff (rst)
        blocked_writes <= fifo_pkg::DEPTH + 8)
    else begin
        fail_count++;
        $error("Mismatch accepted words without a read: expected at most %0d actual %0d",
               fifo_pkg::DEPTH + 8, $sampled(blocked_writes));
    end

    a_drain: assert property (@(posedge clk) disable iff (rst)
        starve < DRAIN_LIMIT)
    else begin
        fail_count++;
        $error("Mismatch drain: expected a read within %0d cycles actual %0d idle cycles",
               DRAIN_LIMIT, $sampled(starve));
    end

endmodule

bind stream_fifo_top stream_fifo_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .write_tdata  (write_tdata),
    .write_tvalid (write_tvalid),
    .write_tready (write_tready),
    .read_tdata   (read_tdata),
    .read_tvalid  (read_tvalid),
    .read_tready  (read_tready)
);

`default_nettype wire

//--- tests/tb_stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stream_fifo;

    localparam int          CLK_HALF     = 50;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] LFSR_SEED    = 32'h0963997c;
    localparam logic [31:0] LFSR_TAPS    = 32'hb4bcd35c; // maximal length taps in right shift form

    // test lengths in clock cycles
    localparam int IDLE_CYCLES     = 8;
    localparam int MIXED_CYCLES    = 1500;
    localparam int FILL_CYCLES     = fifo_pkg::DEPTH + 24;
    localparam int DRAIN_CYCLES    = 4 * fifo_pkg::DEPTH + 16;
    localparam int PRESSURE_CYCLES = 1500;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + IDLE_CYCLES + MIXED_CYCLES + FILL_CYCLES
                                     + DRAIN_CYCLES + PRESSURE_CYCLES + DRAIN_CYCLES;
    localparam int MARGIN_CYCLES   = 200;

    logic                            clk;
    logic                            rst;
    logic [fifo_pkg::DATA_WIDTH-1:0] write_tdata;
    logic                            write_tvalid;
    logic                            write_tready;
    logic [fifo_pkg::DATA_WIDTH-1:0] read_tdata;
    logic                            read_tvalid;
    logic                            read_tready;

    logic [31:0] lfsr_state;
    int          tests_passed;
    int          tests_failed;

    stream_fifo_top i_stream_fifo_top (
        .clk          (clk),
        .rst          (rst),
        .write_tdata  (write_tdata),
        .write_tvalid (write_tvalid),
        .write_tready (write_tready),
        .read_tdata   (read_tdata),
        .read_tvalid  (read_tvalid),
        .read_tready  (read_tready)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int count, output logic [fifo_pkg::DATA_WIDTH-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[fifo_pkg::DATA_WIDTH-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // high with a chance of quarters/4
    task automatic pick_level(input int quarters, output logic level);
        logic [fifo_pkg::DATA_WIDTH-1:0] bits;
        if (quarters >= 4) begin
            level = 1'b1;
        end else if (quarters <= 0) begin
            level = 1'b0;
        end else begin
            draw_bits(2, bits);
            level = (bits[1:0] < quarters);
        end
    endtask

    task automatic report_test(input string name, input int fails);
        if (fails == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d assertion errors", name, fails);
        end
    endtask

    task automatic run_traffic(input string name, input int cycles,
                               input int valid_quarters, input int ready_quarters);
        logic                            valid_bit;
        logic                            ready_bit;
        logic [fifo_pkg::DATA_WIDTH-1:0] word;
        int                              fails_before;
        fails_before = i_stream_fifo_top.u_chk.fail_count;
        for (int n = 0; n < cycles; n++) begin
            pick_level(valid_quarters, valid_bit);
            pick_level(ready_quarters, ready_bit);
            @(posedge clk);
            // source keeps valid and data until the word is taken
            if (!write_tvalid || write_tready) begin
                if (valid_bit) begin
                    draw_bits(fifo_pkg::DATA_WIDTH, word);
                    write_tdata <= word;
                end
                write_tvalid <= valid_bit;
            end
            read_tready <= ready_bit; // sink may drop ready at any time
        end
        report_test(name, i_stream_fifo_top.u_chk.fail_count - fails_before);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        write_tdata  = '0;
        write_tvalid = 1'b0;
        read_tready  = 1'b0;
        lfsr_state   = LFSR_SEED;
        tests_passed = 0;
        tests_failed = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        run_traffic("reset_idle", IDLE_CYCLES, 0, 4);
        run_traffic("random_mixed", MIXED_CYCLES, 2, 2);
        run_traffic("fill_blocked", FILL_CYCLES, 4, 0); // read side held off
        run_traffic("drain", DRAIN_CYCLES, 0, 4);
        run_traffic("random_pressure", PRESSURE_CYCLES, 3, 1);
        run_traffic("final_drain", DRAIN_CYCLES, 0, 4);

        $display("tests passed: %0d, tests failed: %0d, assertion errors: %0d",
                 tests_passed, tests_failed, i_stream_fifo_top.u_chk.fail_count);
        if (tests_failed == 0 && i_stream_fifo_top.u_chk.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * 2 * CLK_HALF);
        $display("timeout: run did not finish within %0d clock cycles",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
